//--- rtl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// line geometry: 32-byte lines, 8 sets
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS 3
`define CACHE_LINE_BITS 256

// associativity
`define CACHE_WAYS 4

// memory model response latency in cycles
`define PMEM_DELAY 4

`endif

//--- rtl/cache_types_pkg.sv
`include "cache_cfg.svh"
`default_nettype none

package cache_types_pkg;

    localparam int tag_bits = 32 - `CACHE_OFFSET_BITS - `CACHE_INDEX_BITS;

    typedef logic [31:0] addr_t;
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [`CACHE_LINE_BITS/8-1:0] bmask_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [`CACHE_WAYS-1:0] way_mask_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } meta_t;

endpackage

`default_nettype wire

//--- rtl/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill
    } ctrl_state_t;

    // data array input source
    typedef enum logic {
        din_cpu,
        din_pmem
    } din_sel_t;

    // per-way byte write enable source
    typedef enum logic [1:0] {
        we_zeros,
        we_ones,
        we_mask
    } we_sel_t;

    typedef enum logic {
        paddr_req,
        paddr_victim
    } paddr_sel_t;

endpackage

`default_nettype wire

//--- rtl/meta_array.sv
`include "cache_cfg.svh"
`default_nettype none

module meta_array
    import cache_types_pkg::*;
#(
    parameter type T = logic,
    parameter int index_bits = `CACHE_INDEX_BITS
) (
    input  wire logic   clk,
    input  wire logic   rst_i,
    input  wire logic   load_i,
    input  wire index_t index_i,
    input  wire T       data_i,
    output T            data_o
);

    T entries [1 << index_bits];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < (1 << index_bits); i++) begin
                entries[i] <= '0;
            end
        end else if (load_i) begin
            entries[index_i] <= data_i;
        end
    end

    assign data_o = entries[index_i];

endmodule

`default_nettype wire

//--- rtl/data_array.sv
`include "cache_cfg.svh"
`default_nettype none

module data_array
    import cache_types_pkg::*;
(
    input  wire logic   clk,
    input  wire index_t index_i,
    input  wire bmask_t we_i,
    input  wire line_t  data_i,
    output line_t       data_o
);

    localparam int sets = 1 << `CACHE_INDEX_BITS;
    localparam int bytes = $bits(bmask_t);

    line_t lines [sets];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < bytes; b++) begin
            if (we_i[b]) begin
                lines[index_i][8*b +: 8] <= data_i[8*b +: 8];
            end
        end
    end

    assign data_o = lines[index_i];

endmodule

`default_nettype wire

//--- rtl/plru_tree.sv
`include "cache_cfg.svh"
`default_nettype none

module plru_tree
    import cache_types_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_i,
    input  wire index_t index_i,
    input  wire logic   update_i,
    input  wire way_t   hit_way_i,
    output way_t        victim_o
);

    localparam int sets = 1 << `CACHE_INDEX_BITS;

    // bit 0 is the root, set means the victim is in ways 2/3
    // bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [2:0] tree_q [sets];
    logic [2:0] cur;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (update_i) begin
            if (hit_way_i[1]) begin
                tree_q[index_i][0] <= 1'b0;
                tree_q[index_i][2] <= ~hit_way_i[0];
            end else begin
                tree_q[index_i][0] <= 1'b1;
                tree_q[index_i][1] <= ~hit_way_i[0];
            end
        end
    end

    assign cur = tree_q[index_i];
    assign victim_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    hit_way_known_a: assert property (@(posedge clk) disable iff (rst_i)
        update_i |-> !$isunknown(hit_way_i));

endmodule

`default_nettype wire

//--- rtl/cache_datapath.sv
`include "cache_cfg.svh"
`default_nettype none

module cache_datapath
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_i,
    input  wire addr_t      address_i,
    input  wire line_t      wdata_i,
    input  wire bmask_t     byte_enable_i,
    input  wire line_t      pmem_rdata_i,
    input  wire din_sel_t   din_sel_i,
    input  wire we_sel_t    we_sel_i [`CACHE_WAYS],
    input  wire paddr_sel_t paddr_sel_i,
    input  wire way_mask_t  tag_load_i,
    input  wire way_mask_t  meta_load_i,
    input  wire meta_t      meta_in_i,
    input  wire logic       lru_update_i,
    output way_mask_t       hit_o,
    output way_t            hit_way_o,
    output way_t            victim_way_o,
    output meta_t           victim_meta_o,
    output line_t           rdata_o,
    output line_t           pmem_wdata_o,
    output addr_t           pmem_address_o
);

    addr_fields_t fields;
    line_t        din;
    way_t         plru_way;
    tag_t         tag_out [`CACHE_WAYS];
    meta_t        meta_out [`CACHE_WAYS];
    line_t        data_out [`CACHE_WAYS];
    bmask_t       we [`CACHE_WAYS];

    assign fields = address_i;
    assign din = (din_sel_i == din_pmem) ? pmem_rdata_i : wdata_i;

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        meta_array #(.T(tag_t)) u_tag (
            .clk, .rst_i, .load_i(tag_load_i[w]), .index_i(fields.index),
            .data_i(fields.tag), .data_o(tag_out[w])
        );
        meta_array #(.T(meta_t)) u_meta (
            .clk, .rst_i, .load_i(meta_load_i[w]), .index_i(fields.index),
            .data_i(meta_in_i), .data_o(meta_out[w])
        );
        data_array u_data (
            .clk, .index_i(fields.index), .we_i(we[w]), .data_i(din), .data_o(data_out[w])
        );
    end

    plru_tree u_plru (
        .clk, .rst_i, .index_i(fields.index), .update_i(lru_update_i),
        .hit_way_i(hit_way_o), .victim_o(plru_way)
    );

    always_comb begin
        hit_way_o = '0;
        victim_way_o = plru_way;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            hit_o[i] = meta_out[i].valid && (tag_out[i] == fields.tag);
            if (hit_o[i]) begin
                hit_way_o = way_t'(i);
            end
            unique case (we_sel_i[i])
                we_ones: we[i] = '1;
                we_mask: we[i] = byte_enable_i;
                default: we[i] = '0;
            endcase
        end
        // lowest invalid way beats the tree
        for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
            if (!meta_out[i].valid) begin
                victim_way_o = way_t'(i);
            end
        end
    end

    assign victim_meta_o = meta_out[victim_way_o];
    assign rdata_o = data_out[hit_way_o];
    assign pmem_wdata_o = data_out[victim_way_o];
    assign pmem_address_o = (paddr_sel_i == paddr_victim) ?
        {tag_out[victim_way_o], fields.index, offset_t'(0)} :
        {fields.tag, fields.index, offset_t'(0)};

    hit_onehot_a: assert property (@(posedge clk) disable iff (rst_i) $onehot0(hit_o));

endmodule

`default_nettype wire

//--- rtl/cache_control.sv
`include "cache_cfg.svh"
`default_nettype none

module cache_control
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_i,
    input  wire logic      mem_read_i,
    input  wire logic      mem_write_i,
    input  wire logic      pmem_resp_i,
    input  wire way_mask_t hit_i,
    input  wire way_t      hit_way_i,
    input  wire way_t      victim_way_i,
    input  wire meta_t     victim_meta_i,
    output din_sel_t       din_sel_o,
    output we_sel_t        we_sel_o [`CACHE_WAYS],
    output paddr_sel_t     paddr_sel_o,
    output way_mask_t      tag_load_o,
    output way_mask_t      meta_load_o,
    output meta_t          meta_in_o,
    output logic           lru_update_o,
    output logic           mem_resp_o,
    output logic           pmem_read_o,
    output logic           pmem_write_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        din_sel_o = din_cpu;
        paddr_sel_o = paddr_req;
        tag_load_o = '0;
        meta_load_o = '0;
        meta_in_o = '{valid: 1'b1, dirty: 1'b0};
        lru_update_o = 1'b0;
        mem_resp_o = 1'b0;
        pmem_read_o = 1'b0;
        pmem_write_o = 1'b0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            we_sel_o[i] = we_zeros;
        end

        unique case (state_q)
            st_idle: begin
                if (mem_read_i || mem_write_i) begin
                    state_d = st_compare;
                end
            end
            st_compare: begin
                if (|hit_i) begin
                    mem_resp_o = 1'b1;
                    lru_update_o = 1'b1;
                    state_d = st_idle;
                    if (mem_write_i) begin
                        we_sel_o[hit_way_i] = we_mask;
                        meta_load_o[hit_way_i] = 1'b1;
                        meta_in_o = '{valid: 1'b1, dirty: 1'b1};
                    end
                end else if (victim_meta_i.valid && victim_meta_i.dirty) begin
                    state_d = st_writeback;
                end else begin
                    state_d = st_fill;
                end
            end
            st_writeback: begin
                pmem_write_o = 1'b1;
                paddr_sel_o = paddr_victim;
                if (pmem_resp_i) begin
                    state_d = st_fill;
                end
            end
            st_fill: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    // new line lands clean; compare then hits
                    din_sel_o = din_pmem;
                    we_sel_o[victim_way_i] = we_ones;
                    tag_load_o[victim_way_i] = 1'b1;
                    meta_load_o[victim_way_i] = 1'b1;
                    state_d = st_compare;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    pmem_excl_a: assert property (@(posedge clk) disable iff (rst_i)
        !(pmem_read_o && pmem_write_o));

endmodule

`default_nettype wire

//--- rtl/cache.sv
`include "cache_cfg.svh"
`default_nettype none

module cache
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_i,
    input  wire logic   mem_read_i,
    input  wire logic   mem_write_i,
    input  wire addr_t  mem_address_i,
    input  wire line_t  mem_wdata_i,
    input  wire bmask_t mem_byte_enable_i,
    output line_t       mem_rdata_o,
    output logic        mem_resp_o,
    output logic        pmem_read_o,
    output logic        pmem_write_o,
    output addr_t       pmem_address_o,
    output line_t       pmem_wdata_o,
    input  wire line_t  pmem_rdata_i,
    input  wire logic   pmem_resp_i
);

    din_sel_t   din_sel;
    we_sel_t    we_sel [`CACHE_WAYS];
    paddr_sel_t paddr_sel;
    way_mask_t  tag_load;
    way_mask_t  meta_load;
    meta_t      meta_in;
    logic       lru_update;
    way_mask_t  hit;
    way_t       hit_way;
    way_t       victim_way;
    meta_t      victim_meta;

    cache_control u_control (
        .clk, .rst_i, .mem_read_i, .mem_write_i, .pmem_resp_i,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_meta_i(victim_meta), .din_sel_o(din_sel), .we_sel_o(we_sel),
        .paddr_sel_o(paddr_sel), .tag_load_o(tag_load), .meta_load_o(meta_load),
        .meta_in_o(meta_in), .lru_update_o(lru_update), .mem_resp_o,
        .pmem_read_o, .pmem_write_o
    );

    cache_datapath u_datapath (
        .clk, .rst_i, .address_i(mem_address_i), .wdata_i(mem_wdata_i),
        .byte_enable_i(mem_byte_enable_i), .pmem_rdata_i,
        .din_sel_i(din_sel), .we_sel_i(we_sel), .paddr_sel_i(paddr_sel),
        .tag_load_i(tag_load), .meta_load_i(meta_load), .meta_in_i(meta_in),
        .lru_update_i(lru_update), .hit_o(hit), .hit_way_o(hit_way),
        .victim_way_o(victim_way), .victim_meta_o(victim_meta),
        .rdata_o(mem_rdata_o), .pmem_wdata_o, .pmem_address_o
    );

endmodule

`default_nettype wire

//--- bench/pmem_model.sv
`include "cache_cfg.svh"
`default_nettype none

module pmem_model
    import cache_types_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_i,
    input  wire logic  read_i,
    input  wire logic  write_i,
    input  wire addr_t address_i,
    input  wire line_t wdata_i,
    output line_t      rdata_o,
    output logic       resp_o
);

    line_t store [addr_t];
    int    wait_cnt;
    // writeback record
    int    wb_count;
    addr_t last_wb_addr;

    // untouched lines: byte n holds the low address byte plus n
    function automatic line_t initial_line(addr_t a);
        line_t l;
        for (int b = 0; b < $bits(bmask_t); b++) begin
            l[8*b +: 8] = a[7:0] + 8'(b);
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            resp_o <= 1'b0;
            rdata_o <= '0;
            wait_cnt <= 0;
            wb_count = 0;
        end else if (resp_o) begin
            resp_o <= 1'b0;
            wait_cnt <= 0;
        end else if (read_i || write_i) begin
            if (wait_cnt == `PMEM_DELAY - 1) begin
                resp_o <= 1'b1;
                if (write_i) begin
                    store[address_i] = wdata_i;
                    last_wb_addr = address_i;
                    wb_count = wb_count + 1;
                end else if (store.exists(address_i)) begin
                    rdata_o <= store[address_i];
                end else begin
                    rdata_o <= initial_line(address_i);
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/cache_tb.sv
`include "cache_cfg.svh"
`default_nettype none

module cache_tb
    import cache_types_pkg::*;
();

    localparam int kind_any = 0;
    localparam int kind_hit = 1;
    localparam int kind_miss = 2;
    // 83 requests, each at most a dirty miss plus the idle cycle after it
    localparam int requests = 83;
    localparam int cycle_limit = requests * (2 * `PMEM_DELAY + 6) + 10;

    logic   clk;
    logic   rst_i;
    logic   mem_read;
    logic   mem_write;
    addr_t  mem_address;
    line_t  mem_wdata;
    bmask_t mem_byte_enable;
    line_t  mem_rdata;
    logic   mem_resp;
    logic   pmem_read;
    logic   pmem_write;
    addr_t  pmem_address;
    line_t  pmem_wdata;
    line_t  pmem_rdata;
    logic   pmem_resp;

    line_t  shadow [addr_t];
    line_t  exp_line;
    line_t  wb_expect;
    logic   hit_required;
    string  test_name;
    integer seed;
    int     errors;
    int     test_start;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;

    cache cache_i (
        .clk, .rst_i, .mem_read_i(mem_read), .mem_write_i(mem_write),
        .mem_address_i(mem_address), .mem_wdata_i(mem_wdata),
        .mem_byte_enable_i(mem_byte_enable), .mem_rdata_o(mem_rdata),
        .mem_resp_o(mem_resp), .pmem_read_o(pmem_read), .pmem_write_o(pmem_write),
        .pmem_address_o(pmem_address), .pmem_wdata_o(pmem_wdata),
        .pmem_rdata_i(pmem_rdata), .pmem_resp_i(pmem_resp)
    );

    pmem_model pmem_i (
        .clk, .rst_i, .read_i(pmem_read), .write_i(pmem_write),
        .address_i(pmem_address), .wdata_i(pmem_wdata),
        .rdata_o(pmem_rdata), .resp_o(pmem_resp)
    );

    always #10 clk = ~clk;

    function automatic addr_t line_of(addr_t a);
        return a & ~addr_t'((1 << `CACHE_OFFSET_BITS) - 1);
    endfunction

    // lines never written hold the low address byte plus the byte position
    function automatic line_t shadow_line(addr_t a);
        line_t l;
        addr_t base;
        base = line_of(a);
        if (shadow.exists(base)) begin
            return shadow[base];
        end
        for (int b = 0; b < $bits(bmask_t); b++) begin
            l[8*b +: 8] = base[7:0] + 8'(b);
        end
        return l;
    endfunction

    always @(negedge clk) begin
        wb_expect <= shadow_line(pmem_address);
    end

    read_data_a: assert property (@(posedge clk) disable iff (rst_i)
        (mem_resp && mem_read) |-> (mem_rdata == exp_line))
        else begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", test_name, exp_line,
                     $sampled(mem_rdata));
        end

    hit_quiet_a: assert property (@(posedge clk) disable iff (rst_i)
        hit_required |-> !(pmem_read || pmem_write))
        else begin
            errors++;
            $display("ERROR %s: memory port active on a request that must hit", test_name);
        end

    wb_data_a: assert property (@(posedge clk) disable iff (rst_i)
        pmem_write |-> (pmem_wdata == wb_expect))
        else begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", test_name, wb_expect,
                     $sampled(pmem_wdata));
        end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic access(input logic wr, input addr_t a, input line_t d, input bmask_t m,
                          input int kind);
        line_t merged;
        int cycles;
        merged = shadow_line(a);
        for (int b = 0; b < $bits(bmask_t); b++) begin
            if (wr && m[b]) begin
                merged[8*b +: 8] = d[8*b +: 8];
            end
        end
        @(negedge clk);
        mem_read = !wr;
        mem_write = wr;
        mem_address = a;
        mem_wdata = d;
        mem_byte_enable = m;
        exp_line = merged;
        hit_required = (kind == kind_hit);
        if (wr) begin
            shadow[line_of(a)] = merged;
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mem_resp && cycles < cycle_limit);
        // hold through the response edge, then go idle for a cycle
        @(negedge clk);
        mem_read = 1'b0;
        mem_write = 1'b0;
        hit_required = 1'b0;
        if (kind == kind_hit) begin
            hit_latency_a: assert (cycles == 1) else begin
                errors++;
                $display("MISMATCH %s: expected %0d actual %0d", test_name, 1, cycles);
            end
        end else if (kind == kind_miss) begin
            miss_a: assert (cycles > 1) else begin
                errors++;
                $display("ERROR %s: address %h hit but should have missed", test_name, a);
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_start);
        end
    endtask

    initial begin
        int r;
        int wb_before;
        addr_t a;
        line_t d;
        clk = 1'b0;
        rst_i = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        mem_byte_enable = '0;
        exp_line = '0;
        hit_required = 1'b0;
        seed = 32'h7efbe3c8;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        repeat (2) @(negedge clk);
        rst_i = 1'b0;

        begin_test("read_miss_then_hit");
        access(1'b0, 32'h0000_0120, '0, '0, kind_miss);
        access(1'b0, 32'h0000_0120, '0, '0, kind_hit);
        end_test();

        begin_test("partial_write");
        access(1'b1, 32'h0000_0120, {8{32'ha5c3_0f96}}, 32'h0f0f_00f3, kind_hit);
        access(1'b0, 32'h0000_0120, '0, '0, kind_hit);
        end_test();

        // set 2, first way dirty, then four more tags
        begin_test("dirty_eviction");
        access(1'b1, 32'h0000_1040, {8{32'h1234_5678}}, 32'hffff_0000, kind_miss);
        access(1'b0, 32'h0000_2040, '0, '0, kind_miss);
        access(1'b0, 32'h0000_3040, '0, '0, kind_miss);
        access(1'b0, 32'h0000_4040, '0, '0, kind_miss);
        wb_before = pmem_i.wb_count;
        access(1'b0, 32'h0000_5040, '0, '0, kind_miss);
        victim_wb_a: assert (pmem_i.wb_count == wb_before + 1 &&
                             pmem_i.last_wb_addr == 32'h0000_1040) else begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", test_name, 32'h0000_1040,
                     pmem_i.last_wb_addr);
        end
        access(1'b0, 32'h0000_1040, '0, '0, kind_miss);
        end_test();

        // set 5: fill ways 0..3, touch 0 2 1 3, tree then points at way 0
        begin_test("plru_order");
        access(1'b0, 32'h0000_60a0, '0, '0, kind_miss);
        access(1'b0, 32'h0000_70a0, '0, '0, kind_miss);
        access(1'b0, 32'h0000_80a0, '0, '0, kind_miss);
        access(1'b0, 32'h0000_90a0, '0, '0, kind_miss);
        access(1'b0, 32'h0000_60a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_80a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_70a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_90a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_a0a0, '0, '0, kind_miss);
        access(1'b0, 32'h0000_70a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_80a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_90a0, '0, '0, kind_hit);
        access(1'b0, 32'h0000_60a0, '0, '0, kind_miss);
        end_test();

        // eight tags in each of sets 6 and 7
        begin_test("random_mix");
        for (int n = 0; n < 60; n++) begin
            r = $random(seed);
            a = {tag_t'(24'h0000c0 + r[2:0]), index_t'(6 + r[3]), 5'b0};
            for (int k = 0; k < 8; k++) begin
                d[32*k +: 32] = $random(seed);
            end
            access(r[4], a, d, $random(seed), kind_any);
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/cache_types_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/meta_array.sv
rtl/data_array.sv
rtl/plru_tree.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache.sv
bench/pmem_model.sv
bench/cache_tb.sv
